/* Makefile */
TOP := sm83_irq_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f src.f --top-module $(TOP)

sim:
	verilator --binary --assert -f src.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

/* hw/sm83_irq.sv */
`default_nettype none

module sm83_irq
	import sm83_irq_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  irq_vec_t  req,
	input  logic      if_we,
	input  irq_vec_t  if_wdata,
	input  logic      ie_we,
	input  irq_vec_t  ie_wdata,
	input  logic      ime,
	input  logic      ack,
	output irq_vec_t  if_rdata,
	output irq_vec_t  ie_rdata,
	output logic      irq,
	output irq_addr_t vector
);

	irq_vec_t flag_q;
	irq_vec_t ack_clr;
	pend_s    pend;
	grant_s   grant;

	assign if_rdata = flag_q;

	sm83_irq_flags u_flags (
		.clk      (clk),
		.rst      (rst),
		.req      (req),
		.if_we    (if_we),
		.if_wdata (if_wdata),
		.ack_clr  (ack_clr),
		.flag_q   (flag_q)
	);

	sm83_irq_pending u_pending (
		.clk      (clk),
		.rst      (rst),
		.ie_we    (ie_we),
		.ie_wdata (ie_wdata),
		.flag_q   (flag_q),
		.ie_q     (ie_rdata),
		.pend     (pend)
	);

	sm83_irq_prio u_prio (
		.clk   (clk),
		.rst   (rst),
		.ime   (ime),
		.pend  (pend),
		.grant (grant)
	);

	// ack_clr loops back to stage 1 and closes the pipeline
	sm83_irq_dispatch u_dispatch (
		.clk     (clk),
		.rst     (rst),
		.grant   (grant),
		.ack     (ack),
		.irq     (irq),
		.vector  (vector),
		.ack_clr (ack_clr)
	);

endmodule

`default_nettype wire

/* hw/sm83_irq_dispatch.sv */
`default_nettype none

module sm83_irq_dispatch
	import sm83_irq_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  grant_s    grant,
	input  logic      ack,
	output logic      irq,
	output irq_addr_t vector,
	output irq_vec_t  ack_clr
);

	disp_state_e state;
	disp_state_e state_d;
	drain_cnt_t  drain_cnt;
	irq_vec_t    grant_q;
	irq_addr_t   vec_next;
	logic        take;
	logic        done;

	always_comb begin
		vec_next = VEC_BASE + VEC_STRIDE * irq_addr_t'(grant.src); // rst 40, 48, 50, 58, 60
	end

	always_comb begin
		take = (state == IDLE) && (|grant.grant);
		done = (state == ACTIVE) && ack; // ack outside ACTIVE has no effect
	end

	always_comb begin
		state_d = state;
		case (state)
			IDLE: begin
				if (take) begin
					state_d = ACTIVE;
				end
			end
			ACTIVE: begin
				if (done) begin
					state_d = DRAIN;
				end
			end
			DRAIN: begin
				// grants still in flight name a flag that was just cleared
				if (drain_cnt == DRAIN_LAST) begin
					state_d = IDLE;
				end
			end
			default: begin
				state_d = IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state     <= IDLE;
			drain_cnt <= '0;
			irq       <= 1'b0;
			vector    <= VEC_BASE;
			ack_clr   <= '0;
		end else begin
			state <= state_d;
			if (take) begin
				irq    <= 1'b1;
				vector <= vec_next;
			end else if (done) begin
				irq <= 1'b0; // vector keeps the last address
			end
			ack_clr <= done ? grant_q : '0;
			if (state == DRAIN) begin
				drain_cnt <= drain_cnt + 1'b1;
			end else begin
				drain_cnt <= '0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			grant_q <= grant.grant;
		end
	end

endmodule

`default_nettype wire

/* hw/sm83_irq_flags.sv */
`default_nettype none

module sm83_irq_flags
	import sm83_irq_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  irq_vec_t req,
	input  logic     if_we,
	input  irq_vec_t if_wdata,
	input  irq_vec_t ack_clr,
	output irq_vec_t flag_q
);

	irq_vec_t flag_set;
	irq_vec_t flag_d;

	// a cpu write replaces the whole register, including bits a source raises in the same cycle
	always_comb begin
		if (if_we) begin
			flag_set = if_wdata;
		end else begin
			flag_set = flag_q | req; // pending requests stay until acknowledged or written
		end
	end

	always_comb begin
		flag_d = flag_set & ~ack_clr; // acknowledge has the final say on its bit
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			flag_q <= '0;
		end else begin
			flag_q <= flag_d;
		end
	end

endmodule

`default_nettype wire

/* hw/sm83_irq_pending.sv */
`default_nettype none

module sm83_irq_pending
	import sm83_irq_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  logic     ie_we,
	input  irq_vec_t ie_wdata,
	input  irq_vec_t flag_q,
	output irq_vec_t ie_q,
	output pend_s    pend
);

	irq_vec_t ie_d;
	irq_vec_t masked;

	always_comb begin
		if (ie_we) begin
			ie_d = ie_wdata;
		end else begin
			ie_d = ie_q;
		end
	end

	// the mask uses the enable value being written, so a new enable reaches the chain with the register
	always_comb begin
		masked = flag_q & ie_d;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			ie_q <= '0;
		end else begin
			ie_q <= ie_d;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pend <= '0;
		end else begin
			pend.pending <= masked;
			pend.any     <= |masked;
		end
	end

endmodule

`default_nettype wire

/* hw/sm83_irq_pkg.sv */
`default_nettype none

package sm83_irq_pkg;

	localparam int IRQ_N        = 5;
	localparam int SRC_W        = $clog2(IRQ_N);
	localparam int DRAIN_CYCLES = 3; // depth of flags, pending and prio
	localparam int DRAIN_W      = $clog2(DRAIN_CYCLES);

	typedef logic [IRQ_N-1:0]   irq_vec_t; // one bit per source, bit 0 is vblank
	typedef logic [7:0]         irq_addr_t;
	typedef logic [DRAIN_W-1:0] drain_cnt_t;

	localparam irq_addr_t  VEC_BASE   = 8'h40;
	localparam irq_addr_t  VEC_STRIDE = 8'd8;
	localparam drain_cnt_t DRAIN_LAST = drain_cnt_t'(DRAIN_CYCLES - 1);

	typedef enum logic [SRC_W-1:0] {
		SRC_VBLANK = 3'd0,
		SRC_STAT   = 3'd1,
		SRC_TIMER  = 3'd2,
		SRC_SERIAL = 3'd3,
		SRC_JOYPAD = 3'd4
	} irq_src_e;

	typedef enum logic [1:0] {
		IDLE   = 2'd0,
		ACTIVE = 2'd1,
		DRAIN  = 2'd2
	} disp_state_e;

	// snapshot handed from the mask stage to the priority chain
	typedef struct packed {
		irq_vec_t pending;
		logic     any;
	} pend_s;

	// grant is one-hot, src is its index
	typedef struct packed {
		irq_vec_t grant;
		irq_src_e src;
	} grant_s;

endpackage

`default_nettype wire

/* hw/sm83_irq_prio.sv */
`default_nettype none

module sm83_irq_prio
	import sm83_irq_pkg::*;
(
	input  logic   clk,
	input  logic   rst,
	input  logic   ime,
	input  pend_s  pend,
	output grant_s grant
);

	logic [IRQ_N:0] chain;
	irq_vec_t       grant_bits;
	irq_src_e       grant_src;

	always_comb begin
		chain[0] = ime & pend.any; // vblank sits at the head of the chain
	end

	for (genvar i = 0; i < IRQ_N; i++) begin : g_cell
		sm83_irq_prio_bit u_bit (
			.clk       (clk),
			.rst       (rst),
			.pend_bit  (pend.pending[i]),
			.chain_in  (chain[i]),
			.chain_out (chain[i+1]),
			.grant_bit (grant_bits[i])
		);
	end

	// the registered grant is one-hot, so a plain scan finds its index
	always_comb begin
		grant_src = SRC_VBLANK;
		for (int i = IRQ_N - 1; i >= 0; i--) begin
			if (grant_bits[i]) begin
				grant_src = irq_src_e'(SRC_W'(i));
			end
		end
	end

	always_comb begin
		grant.grant = grant_bits;
		grant.src   = grant_src;
	end

endmodule

`default_nettype wire

/* hw/sm83_irq_prio_bit.sv */
`default_nettype none

module sm83_irq_prio_bit (
	input  logic clk,
	input  logic rst,
	input  logic pend_bit,
	input  logic chain_in,
	output logic chain_out,
	output logic grant_bit
);

	logic win;

	always_comb begin
		win = pend_bit & chain_in; // enable reached this cell and its source asks
	end

	// lower priority cells only see the enable when this one stays quiet
	always_comb begin
		chain_out = chain_in & ~pend_bit;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			grant_bit <= 1'b0;
		end else begin
			grant_bit <= win;
		end
	end

endmodule

`default_nettype wire

/* src.f */
hw/sm83_irq_pkg.sv
hw/sm83_irq_prio_bit.sv
hw/sm83_irq_flags.sv
hw/sm83_irq_pending.sv
hw/sm83_irq_prio.sv
hw/sm83_irq_dispatch.sv
hw/sm83_irq.sv
testbench/sm83_irq_checker.sv
testbench/sm83_irq_tb.sv

/* testbench/sm83_irq_checker.sv */
module sm83_irq_checker
	import sm83_irq_pkg::*;
(
	input logic      clk,
	input logic      rst,
	input logic      irq,
	input logic      ack,
	input irq_addr_t vector,
	input irq_vec_t  ack_clr
);

	logic clr_bad = 1'b0;
	logic rst_bad = 1'b0;
	logic hold_bad = 1'b0;
	logic vec_bad = 1'b0;
	logic failed;

	assign failed = clr_bad | rst_bad | hold_bad | vec_bad; // sampled by the testbench

	a_clr_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(ack_clr))
		else begin
			clr_bad = 1'b1;
			$error("ack_clr pulses more than one source");
		end

	// covers every reset cycle and the first cycle after release
	a_rst_quiet: assert property (@(posedge clk) rst |=> !irq)
		else begin
			rst_bad = 1'b1;
			$error("irq high during or right after reset");
		end

	a_vec_hold: assert property (@(posedge clk) disable iff (rst) (irq && !ack) |=> $stable(vector))
		else begin
			hold_bad = 1'b1;
			$error("vector changed while irq waits for ack");
		end

	a_vec_legal: assert property (@(posedge clk) disable iff (rst)
		vector inside {8'h40, 8'h48, 8'h50, 8'h58, 8'h60})
		else begin
			vec_bad = 1'b1;
			$error("vector is not a restart address");
		end

endmodule

bind sm83_irq sm83_irq_checker u_checker (
	.clk     (clk),
	.rst     (rst),
	.irq     (irq),
	.ack     (ack),
	.vector  (vector),
	.ack_clr (ack_clr)
);

/* testbench/sm83_irq_tb.sv */
module sm83_irq_tb
	import sm83_irq_pkg::*;
();

	localparam int PERIOD      = 100;
	localparam int RAND_CYCLES = 3000;
	localparam int TEST_CYCLES = RAND_CYCLES + 200; // directed tests take far fewer than 200

	logic        clk;
	logic        rst;
	irq_vec_t    req;
	logic        if_we;
	irq_vec_t    if_wdata;
	logic        ie_we;
	irq_vec_t    ie_wdata;
	logic        ime;
	logic        ack;
	irq_vec_t    if_rdata;
	irq_vec_t    ie_rdata;
	logic        irq;
	irq_addr_t   vector;
	logic [31:0] lfsr_q;
	irq_vec_t    m_if;
	irq_vec_t    m_ie;
	irq_vec_t    m_pend;
	irq_vec_t    m_grant;
	irq_vec_t    m_held;
	irq_vec_t    m_clr;
	disp_state_e m_state;
	int          m_drain;
	logic        m_irq;
	irq_addr_t   m_vec;

	sm83_irq dut (.*);

	always #(PERIOD / 2) clk = ~clk;

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
			v = {v[30:0], lfsr_q[0]};
		end
		return v;
	endfunction

	// cpu write first, then requests, and acknowledge clears last
	function automatic irq_vec_t next_flags(irq_vec_t cur, irq_vec_t r, logic we, irq_vec_t wd,
		irq_vec_t clr);
		irq_vec_t v;
		v = we ? wd : (cur | r);
		return v & ~clr;
	endfunction

	function automatic int win_index(irq_vec_t v); // -1 when nothing is pending
		int idx;
		idx = -1;
		for (int i = IRQ_N - 1; i >= 0; i--) begin
			if (v[i]) idx = i;
		end
		return idx;
	endfunction

	function automatic irq_addr_t vector_of(int n);
		return irq_addr_t'(8'h40 + 8 * n);
	endfunction

	task automatic fail_and_stop;
		$display("Simulation finished: FAIL");
		$fatal(1);
	endtask

	task automatic check_vec(input string name, input irq_vec_t exp, input irq_vec_t act);
		if (act !== exp) begin
			$display("[ERROR] %0t %s expected %b actual %b", $time, name, exp, act);
			fail_and_stop();
		end
	endtask

	task automatic check_addr(input string name, input irq_addr_t exp, input irq_addr_t act);
		if (act !== exp) begin
			$display("[ERROR] %0t %s expected %h actual %h", $time, name, exp, act);
			fail_and_stop();
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("[ERROR] %0t %s expected %b actual %b", $time, name, exp, act);
			fail_and_stop();
		end
	endtask

	always @(posedge clk) begin : model
		irq_vec_t ie_nx;
		irq_vec_t grant_nx;
		logic     done;
		int       w;
		if (rst) begin
			m_if = '0;
			m_ie = '0;
			m_pend = '0;
			m_grant = '0;
			m_held = '0;
			m_clr = '0;
			m_state = IDLE;
			m_drain = 0;
			m_irq = 1'b0;
			m_vec = 8'h40;
		end else begin
			ie_nx = ie_we ? ie_wdata : m_ie;
			w = win_index(m_pend);
			grant_nx = (ime && w >= 0) ? irq_vec_t'(1 << w) : '0;
			done = (m_state == ACTIVE) && ack;
			m_pend = m_if & ie_nx;
			m_if = next_flags(m_if, req, if_we, if_wdata, m_clr);
			m_ie = ie_nx;
			m_clr = done ? m_held : '0;
			m_drain = (m_state == DRAIN) ? m_drain + 1 : 0;
			case (m_state)
				IDLE: begin
					if (m_grant != '0) begin
						m_state = ACTIVE;
						m_irq = 1'b1;
						m_vec = vector_of(win_index(m_grant));
						m_held = m_grant;
					end
				end
				ACTIVE: begin
					if (ack) begin
						m_state = DRAIN;
						m_irq = 1'b0;
					end
				end
				default: begin
					if (m_drain == DRAIN_CYCLES) m_state = IDLE; // counted after the increment
				end
			endcase
			m_grant = grant_nx;
		end
	end

	always @(negedge clk) begin
		if (!rst) begin
			check_vec("if_rdata", m_if, if_rdata);
			check_vec("ie_rdata", m_ie, ie_rdata);
			check_bit("irq", m_irq, irq);
			check_addr("vector", m_vec, vector);
			if (dut.u_checker.failed) begin
				$display("an assertion in the checker failed");
				fail_and_stop();
			end
		end
	end

	initial begin : watchdog
		#(TEST_CYCLES * PERIOD + 50 * PERIOD);
		$display("watchdog expired before the tests completed");
		fail_and_stop();
	end

	task automatic next_cycle;
		@(posedge clk);
		#10;
		req = '0;
		if_we = 1'b0;
		ie_we = 1'b0;
		ack = 1'b0;
	endtask

	task automatic idle(input int n);
		repeat (n) next_cycle();
	endtask

	task automatic write_if(input irq_vec_t v);
		if_we = 1'b1;
		if_wdata = v;
		next_cycle();
	endtask

	task automatic write_ie(input irq_vec_t v);
		ie_we = 1'b1;
		ie_wdata = v;
		next_cycle();
	endtask

	task automatic pulse_req(input irq_vec_t v);
		req = v;
		next_cycle();
	endtask

	task automatic ack_irq;
		ack = 1'b1;
		next_cycle();
	endtask

	task automatic wait_irq(input int limit);
		int n;
		n = 0;
		while (!irq && n < limit) begin
			next_cycle();
			n++;
		end
		if (!irq) begin
			$display("irq did not rise within %0d cycles", limit);
			fail_and_stop();
		end
	endtask

	initial begin : stimulus
		clk = 1'b0;
		rst = 1'b1;
		req = '0;
		if_we = 1'b0;
		if_wdata = '0;
		ie_we = 1'b0;
		ie_wdata = '0;
		ime = 1'b0;
		ack = 1'b0;
		lfsr_q = 32'h4310;
		repeat (5) @(posedge clk);
		#10;
		rst = 1'b0;
		write_if(5'b10101); // register access and request capture
		write_ie(5'b01010);
		write_if('0);
		pulse_req(5'b01000);
		write_if('0);
		write_ie('0);
		ime = 1'b1; // masked request, then its enable
		pulse_req(5'b00100);
		idle(6);
		write_ie(5'b00100);
		wait_irq(5);
		check_addr("vector", vector_of(2), vector);
		ack_irq();
		idle(5);
		write_ie(5'b11111); // several at once, lowest index wins
		write_if(5'b11010);
		wait_irq(6);
		check_addr("vector", vector_of(1), vector);
		ack_irq();
		wait_irq(12);
		check_addr("vector", vector_of(3), vector);
		ack_irq();
		wait_irq(12);
		check_addr("vector", vector_of(4), vector);
		ack_irq();
		idle(6);
		check_vec("if_rdata", '0, if_rdata);
		ime = 1'b0; // flags gather while ime is low
		pulse_req(5'b10001);
		idle(6);
		ime = 1'b1;
		wait_irq(4);
		check_addr("vector", vector_of(0), vector);
		ack_irq();
		wait_irq(12);
		ack_irq();
		idle(6);
		for (int i = 0; i < RAND_CYCLES; i++) begin
			req = irq_vec_t'(rand_bits(IRQ_N) & rand_bits(IRQ_N));
			if_we = (rand_bits(4) == 0);
			if_wdata = irq_vec_t'(rand_bits(IRQ_N));
			ie_we = (rand_bits(4) == 0);
			ie_wdata = irq_vec_t'(rand_bits(IRQ_N));
			if (rand_bits(3) == 0) ime = ~ime;
			ack = irq && (rand_bits(2) == 0);
			next_cycle();
		end
		idle(2);
		if (dut.u_checker.failed) begin
			$display("an assertion in the checker failed");
			fail_and_stop();
		end else begin
			$display("Simulation finished: PASS");
			$finish;
		end
	end

endmodule
